// File: common/lut_pkg.sv
// lut_pkg with PIO bus widths, address map fields and lookup table geometry
package lut_pkg;

	// PIO bus
	localparam int PIO_NBITS = 32;      // host address and data word width
	localparam int PIO_ADDR_MSB = 15;   // highest address bit the decoder looks at

	// address map
	// byte address, tables are word addressed starting at bit 2
	localparam int ADDR_WORD_LSB = 2;

	// key table below this bit, action table above
	localparam int TBL_SEL_BIT = 12;

	// bits from here up to PIO_ADDR_MSB must be zero for a table hit
	localparam int MAP_LSB = TBL_SEL_BIT + 1;

	// table geometry
	// key table is 2**KEY_NBITS deep, IDX_NBITS wide
	localparam int KEY_NBITS = 6;       // lookup key width

	// action table is 2**IDX_NBITS deep, ACT_NBITS wide
	localparam int IDX_NBITS = 5;       // action index width
	localparam int ACT_NBITS = 20;      // action word width

	// key table spans 256 bytes, action table 128 bytes
	// both fit well inside one 4 KB select window

endpackage

// File: common/pio_if.sv
// pio_if interface, one table's PIO select, strobes, data and acknowledge
`timescale 1ns/1ps

interface pio_if #(
	parameter int WIDTH = lut_pkg::PIO_NBITS // data width of the table behind it
);

	// request side, driven by the decoder
	logic [lut_pkg::PIO_NBITS-1:0] addr;   // byte address from host
	logic [WIDTH-1:0] din;                 // write data, already cut to table width
	logic rd;                              // one-cycle read strobe
	logic wr;                              // one-cycle write strobe
	logic ms;                              // this table is addressed

	// response side, driven by the table
	logic ack;                             // clk_div aligned acknowledge
	logic [lut_pkg::PIO_NBITS-1:0] rdata;  // zero-extended read data, held

	modport host (
		output addr,
		output din,
		output rd,
		output wr,
		output ms,
		input  ack,
		input  rdata
	);

	modport mem (
		input  addr,
		input  din,
		input  rd,
		input  wr,
		input  ms,
		output ack,
		output rdata
	);

endinterface

// File: pio_mem/ram_1r1w.sv
// ram_1r1w, simple dual-port block RAM with registered read
`timescale 1ns/1ps

module ram_1r1w #(
	parameter int WIDTH = 20,
	parameter int DEPTH_NBITS = 1
) (
	input  logic clk,
	input  logic wr,
	input  logic [DEPTH_NBITS-1:0] waddr,
	input  logic [DEPTH_NBITS-1:0] raddr,
	input  logic [WIDTH-1:0] din,
	output logic [WIDTH-1:0] dout
);

	logic [WIDTH-1:0] mem [0:(1<<DEPTH_NBITS)-1];

	// same-address read and write returns the old word
	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= din;
		end
		dout <= mem[raddr];     // read register, maps onto the bram output latch
	end

endmodule

// File: pio_mem/pio_mem_bram_wo.sv
// pio_mem_bram_wo, PIO table with shared read port, lookup priority and saved host read
`timescale 1ns/1ps

module pio_mem_bram_wo #(
	parameter int WIDTH = 20,        // table word width
	parameter int DEPTH_NBITS = 1    // log2 of table depth
) (
	input  logic clk,
	input  logic rst,
	input  logic clk_div,
	input  logic app_mem_rd,                     // lookup read request, one cycle
	input  logic [DEPTH_NBITS-1:0] app_mem_raddr,
	pio_if.mem bus,
	output logic wr_active,                      // write mirror, one cycle after the write
	output logic [DEPTH_NBITS-1:0] wr_addr,
	output logic [WIDTH-1:0] wr_data,
	output logic app_mem_ack,
	output logic [WIDTH-1:0] app_mem_rdata
);

	logic [DEPTH_NBITS-1:0] host_addr;   // word address of the host access
	logic [WIDTH-1:0] ram_wdata;
	logic [DEPTH_NBITS-1:0] ram_raddr;
	logic [WIDTH-1:0] ram_rdata;
	logic ram_wr;
	logic ram_rd;

	logic app_rd_d1;                     // lookup owns the read port this cycle
	logic [DEPTH_NBITS-1:0] app_raddr_d1;
	logic rd_save;                       // host read lost arbitration, still owed
	logic [DEPTH_NBITS-1:0] save_addr;   // host may drop reg_addr after its strobe
	logic rd_go;                         // host read gets the ram this cycle
	logic rd_go_d1;                      // host read data on ram_rdata
	logic n_mem_ack;                     // ack armed, waiting for clk_div

	assign host_addr = bus.addr[lut_pkg::ADDR_WORD_LSB +: DEPTH_NBITS];
	assign ram_wdata = bus.din;
	assign ram_wr = bus.ms & bus.wr;
	assign ram_rd = bus.ms & bus.rd;

	// lookup first, then an owed host read, else the live host address
	assign ram_raddr = app_rd_d1 ? app_raddr_d1 : rd_save ? save_addr : host_addr;
	assign rd_go = ~app_rd_d1 & (ram_rd | rd_save);

	// lookup data straight off the registered ram output
	assign app_mem_rdata = ram_rdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			app_rd_d1 <= 1'b0;
			app_mem_ack <= 1'b0;
			rd_save <= 1'b0;
			rd_go_d1 <= 1'b0;
			n_mem_ack <= 1'b0;
			bus.ack <= 1'b0;
			wr_active <= 1'b0;
		end else begin
			app_rd_d1 <= app_mem_rd;
			app_mem_ack <= app_rd_d1;         // lines up with ram_rdata
			// collision sets it, the first free cycle serves and clears it
			rd_save <= (app_rd_d1 & ram_rd) ? 1'b1 : ~app_rd_d1 ? 1'b0 : rd_save;
			rd_go_d1 <= rd_go;
			n_mem_ack <= (ram_wr | rd_go_d1) ? 1'b1 : clk_div ? 1'b0 : n_mem_ack;
			bus.ack <= clk_div ? n_mem_ack : bus.ack;  // moves on clk_div only
			wr_active <= ram_wr;
		end
	end

	always_ff @(posedge clk) begin
		app_raddr_d1 <= app_mem_raddr;
		if (app_rd_d1 & ram_rd) begin
			save_addr <= host_addr;
		end
		if (rd_go_d1) begin
			bus.rdata <= {{(lut_pkg::PIO_NBITS-WIDTH){1'b0}}, ram_rdata};  // held till next read
		end
		wr_addr <= host_addr;
		wr_data <= ram_wdata;
	end

	// host writes never wait, the write port is private
	ram_1r1w #(
		.WIDTH(WIDTH),
		.DEPTH_NBITS(DEPTH_NBITS)
	) ram_i (
		.clk(clk),
		.wr(ram_wr),
		.waddr(host_addr),
		.raddr(ram_raddr),
		.din(ram_wdata),
		.dout(ram_rdata)
	);

endmodule

// File: src/pio_decode.sv
// pio_decode, host address decode into table selects with ack and read data merge
`timescale 1ns/1ps

module pio_decode (
	input  logic clk,
	input  logic rst,
	input  logic clk_div,                          // one-cycle host bus enable
	input  logic [lut_pkg::PIO_NBITS-1:0] reg_addr,
	input  logic [lut_pkg::PIO_NBITS-1:0] reg_din,
	input  logic reg_rd,
	input  logic reg_wr,
	output logic pio_ack,
	output logic [lut_pkg::PIO_NBITS-1:0] pio_rdata,
	pio_if.host key_bus,
	pio_if.host act_bus
);

	logic mapped;     // address falls in one of the two tables
	logic host_req;   // any host strobe this cycle
	logic unm_req;    // strobe to a hole in the map
	logic unm_pend;   // unmapped access waiting for clk_div
	logic unm_ack;    // locally generated acknowledge
	logic src_act;    // last access went to the action table
	logic src_unm;    // last access hit nothing

	// upper window bits must be clear, bits above PIO_ADDR_MSB are ignored
	assign mapped = (reg_addr[lut_pkg::PIO_ADDR_MSB:lut_pkg::MAP_LSB] == '0);
	assign host_req = reg_rd | reg_wr;
	assign unm_req = host_req & ~mapped;

	// both tables see the same cycle, only ms differs
	assign key_bus.addr = reg_addr;
	assign key_bus.din = reg_din[$bits(key_bus.din)-1:0];  // table keeps its own width
	assign key_bus.rd = reg_rd;
	assign key_bus.wr = reg_wr;
	assign key_bus.ms = mapped & ~reg_addr[lut_pkg::TBL_SEL_BIT];

	assign act_bus.addr = reg_addr;
	assign act_bus.din = reg_din[$bits(act_bus.din)-1:0];
	assign act_bus.rd = reg_rd;
	assign act_bus.wr = reg_wr;
	assign act_bus.ms = mapped & reg_addr[lut_pkg::TBL_SEL_BIT];

	// remember the target so its rdata stays on pio_rdata until the next request
	always_ff @(posedge clk) begin
		if (rst) begin
			src_act <= 1'b0;
			src_unm <= 1'b0;
		end else if (host_req) begin
			src_act <= reg_addr[lut_pkg::TBL_SEL_BIT];
			src_unm <= ~mapped;
		end
	end

	// unmapped access, same clk_div stretch as the tables use
	always_ff @(posedge clk) begin
		if (rst) begin
			unm_pend <= 1'b0;
			unm_ack <= 1'b0;
		end else begin
			unm_pend <= unm_req ? 1'b1 : clk_div ? 1'b0 : unm_pend;  // set wins over clear
			unm_ack <= clk_div ? unm_pend : unm_ack;                 // rise, then fall a div later
		end
	end

	// only the addressed target ever acks, so an or is enough
	assign pio_ack = key_bus.ack | act_bus.ack | unm_ack;

	always_comb begin
		if (src_unm) begin
			pio_rdata = '0;               // holes read as zero
		end else if (src_act) begin
			pio_rdata = act_bus.rdata;
		end else begin
			pio_rdata = key_bus.rdata;
		end
	end

endmodule

// File: src/app_lookup.sv
// app_lookup, chained key then action table lookup with key delay line
`timescale 1ns/1ps

module app_lookup #(
	parameter int KEY_NBITS = 6,
	parameter int IDX_NBITS = 5,
	parameter int ACT_NBITS = 20
) (
	input  logic clk,
	input  logic rst,
	input  logic lookup_req,                    // one key per cycle, no stall
	input  logic [KEY_NBITS-1:0] lookup_key_in,
	output logic key_rd,                        // key table read port
	output logic [KEY_NBITS-1:0] key_raddr,
	input  logic key_ack,
	input  logic [IDX_NBITS-1:0] key_rdata,     // action index
	output logic act_rd,                        // action table read port
	output logic [IDX_NBITS-1:0] act_raddr,
	input  logic act_ack,
	input  logic [ACT_NBITS-1:0] act_rdata,
	output logic lookup_valid,
	output logic [KEY_NBITS-1:0] lookup_key,
	output logic [ACT_NBITS-1:0] lookup_action
);

	localparam int DLY = 4;                      // keys in flight

	logic [KEY_NBITS-1:0] key_dly [DLY];         // key riding alongside its result

	// first stage, key goes straight at the key table
	assign key_rd = lookup_req;
	assign key_raddr = lookup_key_in;

	// second stage, returned index chains into the action table same cycle
	assign act_rd = key_ack;
	assign act_raddr = key_rdata;

	// plain shift line, validity comes back through the ack chain
	always_ff @(posedge clk) begin
		key_dly[0] <= lookup_key_in;
		for (int i = 1; i < DLY; i++) begin
			key_dly[i] <= key_dly[i-1];
		end
	end

	// result register, 4 edges after the key was taken
	always_ff @(posedge clk) begin
		if (rst) begin
			lookup_valid <= 1'b0;
		end else begin
			lookup_valid <= act_ack;
		end
	end

	always_ff @(posedge clk) begin
		lookup_key <= key_dly[DLY-1];   // tail of the line meets act_rdata here
		lookup_action <= act_rdata;
	end

endmodule

// File: src/lut_top.sv
// lut_top, PIO decoder, key and action tables and lookup pipeline
`timescale 1ns/1ps

module lut_top #(
	parameter int KEY_NBITS = lut_pkg::KEY_NBITS,
	parameter int IDX_NBITS = lut_pkg::IDX_NBITS,
	parameter int ACT_NBITS = lut_pkg::ACT_NBITS
) (
	input  logic clk,
	input  logic rst,
	input  logic clk_div,
	input  logic [lut_pkg::PIO_NBITS-1:0] reg_addr,
	input  logic [lut_pkg::PIO_NBITS-1:0] reg_din,
	input  logic reg_rd,
	input  logic reg_wr,
	input  logic lookup_req,
	input  logic [KEY_NBITS-1:0] lookup_key_in,
	output logic pio_ack,
	output logic [lut_pkg::PIO_NBITS-1:0] pio_rdata,
	output logic lookup_valid,
	output logic [KEY_NBITS-1:0] lookup_key,
	output logic [ACT_NBITS-1:0] lookup_action
);

	pio_if #(.WIDTH(IDX_NBITS)) key_bus ();   // host side of the key table
	pio_if #(.WIDTH(ACT_NBITS)) act_bus ();   // host side of the action table

	logic key_rd;
	logic [KEY_NBITS-1:0] key_raddr;
	logic key_ack;
	logic [IDX_NBITS-1:0] key_rdata;
	logic act_rd;
	logic [IDX_NBITS-1:0] act_raddr;
	logic act_ack;
	logic [ACT_NBITS-1:0] act_rdata;

	pio_decode pio_decode_i (
		.clk(clk), .rst(rst), .clk_div(clk_div),
		.reg_addr(reg_addr), .reg_din(reg_din), .reg_rd(reg_rd), .reg_wr(reg_wr),
		.pio_ack(pio_ack), .pio_rdata(pio_rdata),
		.key_bus(key_bus), .act_bus(act_bus)
	);

	// key -> action index, write mirror left open
	pio_mem_bram_wo #(.WIDTH(IDX_NBITS), .DEPTH_NBITS(KEY_NBITS)) key_tbl_i (
		.clk(clk), .rst(rst), .clk_div(clk_div),
		.app_mem_rd(key_rd), .app_mem_raddr(key_raddr), .bus(key_bus),
		.wr_active(), .wr_addr(), .wr_data(),
		.app_mem_ack(key_ack), .app_mem_rdata(key_rdata)
	);

	// action index -> action word
	pio_mem_bram_wo #(.WIDTH(ACT_NBITS), .DEPTH_NBITS(IDX_NBITS)) act_tbl_i (
		.clk(clk), .rst(rst), .clk_div(clk_div),
		.app_mem_rd(act_rd), .app_mem_raddr(act_raddr), .bus(act_bus),
		.wr_active(), .wr_addr(), .wr_data(),
		.app_mem_ack(act_ack), .app_mem_rdata(act_rdata)
	);

	app_lookup #(.KEY_NBITS(KEY_NBITS), .IDX_NBITS(IDX_NBITS), .ACT_NBITS(ACT_NBITS)) app_lookup_i (
		.clk(clk), .rst(rst), .lookup_req(lookup_req), .lookup_key_in(lookup_key_in),
		.key_rd(key_rd), .key_raddr(key_raddr), .key_ack(key_ack), .key_rdata(key_rdata),
		.act_rd(act_rd), .act_raddr(act_raddr), .act_ack(act_ack), .act_rdata(act_rdata),
		.lookup_valid(lookup_valid), .lookup_key(lookup_key), .lookup_action(lookup_action)
	);

endmodule

// File: test/tb_pio_tasks.svh
// host bus tasks, xorshift generator and lookup driver for the lut_top testbench

// one xorshift32 step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

function automatic logic [31:0] next_rand();
	rng = xorshift32(rng);   // state lives in the testbench top
	return rng;
endfunction

// single-cycle write strobe, then a full ack pulse
task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
	@(negedge clk);
	reg_addr = addr;
	reg_din = data;
	reg_wr = 1'b1;
	@(negedge clk);
	reg_wr = 1'b0;
	while (!pio_ack) @(negedge clk);
	while (pio_ack) @(negedge clk);   // next request only once ack is back low
endtask

// read strobe, then rdata must hold the expected word for the whole ack pulse
task automatic host_read_check(input logic [31:0] addr, input logic [31:0] exp,
		input string name);
	@(negedge clk);
	reg_addr = addr;
	reg_rd = 1'b1;
	@(negedge clk);
	reg_rd = 1'b0;
	reg_addr = ~addr;   // table has to keep its own copy of the address
	while (!pio_ack) @(negedge clk);
	while (pio_ack) begin
		assert (pio_rdata == exp)
			else value_error(name, "read data", exp, pio_rdata);
		@(negedge clk);
	end
endtask

// one key into the pipe, expected result queued from the table model
task automatic issue_lookup(input logic [lut_pkg::KEY_NBITS-1:0] key);
	@(negedge clk);
	lookup_req = 1'b1;
	lookup_key_in = key;
	exp_due.push_back(cyc + 5);   // sampled next edge, result 4 edges after that
	exp_key.push_back(key);
	exp_act.push_back(act_model[key_model[key]]);
endtask

task automatic end_lookups();
	@(negedge clk);
	lookup_req = 1'b0;
endtask

// back to back random keys, one per cycle
task automatic lookup_stream(input int n);
	logic [31:0] r;
	for (int i = 0; i < n; i++) begin
		r = next_rand();
		issue_lookup(r[lut_pkg::KEY_NBITS-1:0]);
	end
	end_lookups();
endtask

task automatic wait_lookups_done();
	while (exp_key.size() != 0) @(negedge clk);
	@(negedge clk);
endtask

// File: test/tb_top.sv
// lut_top testbench with clock, reset, table model, lookup checker and timeout
`timescale 1ns/1ps

module tb_top;

	localparam int N_KEY = 1 << lut_pkg::KEY_NBITS;    // key table depth
	localparam int N_ACT = 1 << lut_pkg::IDX_NBITS;    // action table depth
	localparam int N_LOOKUP = 100;                     // plain random stream
	localparam int BG_LEN = 40;                        // stream that host reads sit behind
	localparam int N_REWRITE = 4;
	localparam int OP_CYCLES = 12;                     // strobe to ack fall, with slack
	localparam int BUS_OPS = 2 * (N_KEY + N_ACT) + 1 + 2 + N_REWRITE;
	localparam int LOOKUP_CYCLES = N_LOOKUP + 2 * BG_LEN + 8 * (3 + N_REWRITE);
	localparam int CYCLE_LIMIT = 2 * (BUS_OPS * OP_CYCLES + LOOKUP_CYCLES + 16);
	localparam logic [31:0] ACT_BASE = 32'h1 << lut_pkg::TBL_SEL_BIT;

	logic clk;
	logic rst;
	logic clk_div;
	logic [31:0] reg_addr;
	logic [31:0] reg_din;
	logic reg_rd;
	logic reg_wr;
	logic lookup_req;
	logic [lut_pkg::KEY_NBITS-1:0] lookup_key_in;
	logic pio_ack;
	logic [31:0] pio_rdata;
	logic lookup_valid;
	logic [lut_pkg::KEY_NBITS-1:0] lookup_key;
	logic [lut_pkg::ACT_NBITS-1:0] lookup_action;

	logic [lut_pkg::IDX_NBITS-1:0] key_model [N_KEY];   // mirror of the key table
	logic [lut_pkg::ACT_NBITS-1:0] act_model [N_ACT];   // mirror of the action table
	int exp_due[$];                                    // cycle each result is owed
	logic [lut_pkg::KEY_NBITS-1:0] exp_key[$];
	logic [lut_pkg::ACT_NBITS-1:0] exp_act[$];
	int cyc = 0;
	int div_cnt;
	logic [31:0] rng;
	string test_name;

	lut_top dut_i (
		.clk(clk), .rst(rst), .clk_div(clk_div),
		.reg_addr(reg_addr), .reg_din(reg_din), .reg_rd(reg_rd), .reg_wr(reg_wr),
		.lookup_req(lookup_req), .lookup_key_in(lookup_key_in),
		.pio_ack(pio_ack), .pio_rdata(pio_rdata),
		.lookup_valid(lookup_valid), .lookup_key(lookup_key), .lookup_action(lookup_action)
	);

	task automatic stop_run();
		$display("Test failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic value_error(input string name, input string field,
			input logic [31:0] exp, input logic [31:0] act);
		$display("Fail %s %s: expected %0h, actual %0h", name, field, exp, act);
		stop_run();
	endtask

	task automatic plain_error(input string what);
		$display("Error in %s: %s", test_name, what);
		stop_run();
	endtask

	`include "tb_pio_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;   // 20 ns period
	end

	// host bus enable, one cycle in four
	initial begin
		div_cnt = 0;
		clk_div = 1'b0;
		forever begin
			@(negedge clk);
			clk_div = (div_cnt == 3);
			div_cnt = (div_cnt + 1) % 4;
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= CYCLE_LIMIT) begin
			$display("Timeout: no end of test after %0d cycles", CYCLE_LIMIT);
			stop_run();
		end
	end

	// lookup results must come in order, each exactly on its due cycle
	always @(negedge clk) begin
		if (!rst) begin
			if (lookup_valid) begin
				assert (exp_key.size() != 0)
					else plain_error("lookup result with no lookup outstanding");
				assert (exp_due[0] == cyc)
					else value_error(test_name, "result cycle", 32'(exp_due[0]), 32'(cyc));
				assert (lookup_key == exp_key[0])
					else value_error(test_name, "result key", 32'(exp_key[0]), 32'(lookup_key));
				assert (lookup_action == exp_act[0])
					else value_error(test_name, "action", 32'(exp_act[0]), 32'(lookup_action));
				void'(exp_due.pop_front());
				void'(exp_key.pop_front());
				void'(exp_act.pop_front());
			end else if (exp_key.size() != 0) begin
				assert (exp_due[0] != cyc)
					else plain_error("lookup result missing on its due cycle");
			end
		end
	end

	initial begin
		logic [31:0] data;
		logic [lut_pkg::KEY_NBITS-1:0] k;
		logic [lut_pkg::IDX_NBITS-1:0] idx;
		rst = 1'b1;
		reg_addr = '0;
		reg_din = '0;
		reg_rd = 1'b0;
		reg_wr = 1'b0;
		lookup_req = 1'b0;
		lookup_key_in = '0;
		rng = 32'h60bbccaf;
		test_name = "reset";
		repeat (2) @(negedge clk);
		rst = 1'b0;

		test_name = "idle after reset";
		repeat (8) begin
			@(negedge clk);
			assert (!pio_ack && !lookup_valid)
				else plain_error("pio_ack or lookup_valid high with no request");
		end

		// fill both tables with random words, upper bits must get dropped
		test_name = "table fill";
		for (int i = 0; i < N_KEY; i++) begin
			data = next_rand();
			host_write(32'(i) << 2, data);
			key_model[i] = data[lut_pkg::IDX_NBITS-1:0];
		end
		for (int i = 0; i < N_ACT; i++) begin
			data = next_rand();
			host_write(ACT_BASE | (32'(i) << 2), data);
			act_model[i] = data[lut_pkg::ACT_NBITS-1:0];
		end
		test_name = "readback";
		for (int i = 0; i < N_KEY; i++) begin
			host_read_check(32'(i) << 2, 32'(key_model[i]), "key table readback");
		end
		for (int i = 0; i < N_ACT; i++) begin
			host_read_check(ACT_BASE | (32'(i) << 2), 32'(act_model[i]), "action readback");
		end

		test_name = "unmapped read";
		host_read_check(32'h2000 | (next_rand() & 32'h1ffc), 32'h0, "unmapped read");

		test_name = "lookup stream";
		lookup_stream(N_LOOKUP);
		wait_lookups_done();

		// host read lands while the table port is busy every cycle
		test_name = "lookups with host reads";
		for (int r = 0; r < 2; r++) begin
			data = next_rand();
			fork
				lookup_stream(BG_LEN);
				begin
					repeat (6) @(negedge clk);
					if (r == 0) begin
						host_read_check(32'(data[5:0]) << 2, 32'(key_model[data[5:0]]),
							"key read under lookups");
					end else begin
						host_read_check(ACT_BASE | (32'(data[4:0]) << 2),
							32'(act_model[data[4:0]]), "action read under lookups");
					end
				end
			join
			wait_lookups_done();
		end

		test_name = "key rewrite";
		for (int n = 0; n < N_REWRITE; n++) begin
			data = next_rand();
			k = data[lut_pkg::KEY_NBITS-1:0];
			idx = key_model[k] ^ (data[12:8] | 5'd1);   // always a different index
			host_write(32'(k) << 2, 32'(idx));
			key_model[k] = idx;
			issue_lookup(k);
			end_lookups();
			wait_lookups_done();
		end

		test_name = "end";
		repeat (4) @(negedge clk);
		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: tb.f
+incdir+test
common/lut_pkg.sv
common/pio_if.sv
pio_mem/ram_1r1w.sv
pio_mem/pio_mem_bram_wo.sv
src/pio_decode.sv
src/app_lookup.sv
src/lut_top.sv
test/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the lut_top testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_top \
	-f tb.f \
	-o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -qx "Test completed successfully" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
